// ==== polyline_lcd.f ====
+incdir+.
polyline_pkg.sv
draw_if.sv
polyline_reader.sv
draw_line.sv
lcd_hvline.sv
polyline_lcd.sv
polyline_lcd_sva.sv
polyline_lcd_tb.sv

// ==== Bender.yml ====
package:
  name: polyline_lcd

sources:
  - include_dirs:
      - .
    files:
      - polyline_pkg.sv
      - draw_if.sv
      - polyline_reader.sv
      - draw_line.sv
      - lcd_hvline.sv
      - polyline_lcd.sv
  - target: test
    include_dirs:
      - .
    files:
      - polyline_lcd_sva.sv
      - polyline_lcd_tb.sv

// ==== polyline_lcd_tb.sv ====
// polyline lcd testbench
`timescale 1ns/1ps
`default_nettype none
`include "polyline_lcd_cfg.svh"

module polyline_lcd_tb import polyline_pkg::*; ();

  logic               clk   = 1'b0;
  logic               reset = 1'b1;
  logic               plot  = 1'b0;
  logic [15:0]        color = '0;
  logic [15:0]        data  = '0; // memory read data
  logic               busy;
  logic [`BUF_AW-1:0] addr;
  logic               rd;
  logic               spi_csn, spi_clk, spi_mosi, spi_dc, spi_resn;

  logic [15:0]        mem [0:(1<<`BUF_AW)-1];
  logic [`BUF_AW-1:0] max_rd;     // highest address read in this polyline
  logic [8:0]         exp_q [$];  // {dc, byte} from the model
  logic [8:0]         got_q [$];  // {dc, byte} seen on the spi pins
  logic [7:0]         rx_sh;
  int                 rx_bits = 0;
  int                 px [0:15];
  int                 py [0:15];
  bit                 ns [0:15];  // new_seg per point
  int                 npts;
  int                 last_bytes; // bytes of the final run
  int                 errors, checks, tests, seed;
  longint             cycles = 0;
  longint             limit;

  polyline_lcd DUT (
    .clk      (clk),
    .reset    (reset),
    .plot     (plot),
    .busy     (busy),
    .data     (data),
    .color    (color),
    .addr     (addr),
    .rd       (rd),
    .spi_csn  (spi_csn),
    .spi_clk  (spi_clk),
    .spi_mosi (spi_mosi),
    .spi_dc   (spi_dc),
    .spi_resn (spi_resn)
  );

  always #2 clk = ~clk; // 4 ns period

  // coordinate memory, one cycle read latency
  always @(posedge clk) begin
    if (plot && !busy)
      max_rd = '0; // new polyline accepted
    else if (rd && addr > max_rd)
      max_rd = addr;
    if (rd)
      data <= mem[addr];
  end

  // spi receiver, display samples on rising spi_clk
  always @(posedge spi_clk) begin
    if (spi_csn === 1'b0) begin
      rx_sh   = {rx_sh[6:0], spi_mosi}; // msb first
      rx_bits = rx_bits + 1;
      if (rx_bits == 8) begin
        got_q.push_back({spi_dc, rx_sh});
        rx_bits = 0;
      end
    end
  end

  // watchdog
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic push_byte(input bit dc, input int b);
    exp_q.push_back({dc, 8'(b)});
  endtask

  // window, RAMWR and pixels of one run
  task automatic add_run(input int rx, input int ry, input int len, input bit vert,
                         input logic [15:0] c);
    int xe, ye, i;
    xe = vert ? rx : rx + len - 1;
    ye = vert ? ry + len - 1 : ry;
    push_byte(0, `CMD_CASET);
    push_byte(1, rx >> 8);
    push_byte(1, rx);
    push_byte(1, xe >> 8);
    push_byte(1, xe);
    push_byte(0, `CMD_RASET);
    push_byte(1, ry >> 8);
    push_byte(1, ry);
    push_byte(1, ye >> 8);
    push_byte(1, ye);
    push_byte(0, `CMD_RAMWR);
    for (i = 0; i < len; i++) begin
      push_byte(1, c[15:8]); // high byte first
      push_byte(1, c[7:0]);
    end
    last_bytes = 11 + 2 * len;
  endtask

  // integer bresenham, pixels grouped by minor coordinate
  task automatic model_line(input int x0, input int y0, input int x1, input int y1,
                            input logic [15:0] c);
    int dx, dy, sx, sy, err, e2, x, y, first, len;
    bit xmaj, stx, sty, done;
    dx    = (x1 >= x0) ? x1 - x0 : x0 - x1;
    dy    = (y1 >= y0) ? y1 - y0 : y0 - y1;
    sx    = (x1 >= x0) ? 1 : -1;
    sy    = (y1 >= y0) ? 1 : -1;
    err   = dx - dy;
    xmaj  = (dx >= dy);
    x     = x0;
    y     = y0;
    first = xmaj ? x0 : y0; // major coordinate of the run's first pixel
    len   = 0;
    done  = 0;
    while (!done) begin
      len++;
      e2   = 2 * err;
      stx  = (e2 > -dy);
      sty  = (e2 < dx);
      done = (x == x1) && (y == y1);
      if (done || (xmaj ? sty : stx)) begin
        if (xmaj)
          add_run((x < first) ? x : first, y, len, 0, c);
        else
          add_run(x, (y < first) ? y : first, len, 1, c);
        len = 0;
      end
      if (!done) begin
        if (stx) begin
          err -= dy;
          x += sx;
        end
        if (sty) begin
          err += dx;
          y += sy;
        end
        if (len == 0)
          first = xmaj ? x : y; // next run starts here
      end
    end
  endtask

  task automatic model_polyline(input logic [15:0] c);
    bit have; // a start point is held
    int i;
    exp_q.delete();
    last_bytes = 0;
    have = 0;
    for (i = 0; i < npts; i++) begin
      if (ns[i])
        have = 0;
      if (have)
        model_line(px[i-1], py[i-1], px[i], py[i], c);
      have = 1;
    end
  endtask

  task automatic load_mem();
    coord_word_u w;
    int a;
    for (a = 0; a < (1 << `BUF_AW); a++)
      mem[a] = 16'(a * 40503) ^ 16'h3c5a; // filler behind the list
    for (a = 0; a < npts; a++) begin
      w.xw.new_seg = ns[a];
      w.xw.x       = coord_t'(px[a]);
      mem[2*a]     = w;
      w.yw.last    = (a == npts - 1);
      w.yw.y       = coord_t'(py[a]);
      mem[2*a+1]   = w;
    end
  endtask

  task automatic set_points(input int n);
    int i;
    npts = n;
    for (i = 0; i < 16; i++)
      ns[i] = 0;
  endtask

  task automatic random_points();
    int i;
    set_points(2 + ({$random(seed)} % 7));
    for (i = 0; i < npts; i++) begin
      px[i] = 180 + ({$random(seed)} % 100); // crosses 255, exercises high bytes
      py[i] = {$random(seed)} % 100;
    end
  endtask

  task automatic compare_stream(input string name, input int base);
    int n, i;
    n = got_q.size() - base;
    checks++;
    assert (n == exp_q.size()) else begin
      $display("Mismatch at %0t: %s expected %0d bytes, received %0d",
               $time, name, exp_q.size(), n);
      errors++;
    end
    for (i = 0; i < n && i < exp_q.size(); i++) begin
      checks++;
      assert (got_q[base+i] == exp_q[i]) else begin
        $display("Mismatch at %0t: %s byte %0d expected dc=%0b 0x%02h, received dc=%0b 0x%02h",
                 $time, name, i, exp_q[i][8], exp_q[i][7:0], got_q[base+i][8],
                 got_q[base+i][7:0]);
        errors++;
      end
    end
  endtask

  task automatic run_polyline(input string name, input logic [15:0] c, input bit extra);
    int base, fall_cnt, errs0;
    errs0 = errors;
    load_mem();
    model_polyline(c);
    limit += (exp_q.size() * 16 + 4 * npts + 160) * 5 / 4; // 16 cycles a byte, 2 per word
    base = got_q.size();
    @(posedge clk);
    plot  <= 1'b1;
    color <= c;
    @(posedge clk);
    plot  <= 1'b0;
    color <= ~c; // must not be picked up again
    @(negedge clk);
    checks++;
    assert (busy) else begin
      $display("busy did not rise one cycle after plot at %0t (%s)", $time, name);
      errors++;
    end
    if (extra) begin // stray strobe while busy
      repeat (4) @(posedge clk);
      plot  <= 1'b1;
      color <= c ^ 16'h0f0f;
      @(posedge clk);
      plot  <= 1'b0;
    end
    while (busy) @(negedge clk);
    fall_cnt = got_q.size() - base;
    while (got_q.size() - base < exp_q.size()) @(negedge clk);
    repeat (64) @(negedge clk); // room for stray bytes
    checks++;
    assert (fall_cnt + 1 >= exp_q.size() - last_bytes && fall_cnt < exp_q.size()) else begin
      $display("busy fell after %0d of %0d bytes, not at the final run (%s)",
               fall_cnt, exp_q.size(), name);
      errors++;
    end
    compare_stream(name, base);
    checks++;
    assert (max_rd == 2 * npts - 1) else begin
      $display("Mismatch at %0t: %s highest read address %0d, expected %0d",
               $time, name, max_rd, 2 * npts - 1);
      errors++;
    end
    tests++;
    $display("test %0d %s: %0d points, %0d bytes, %s", tests, name, npts, exp_q.size(),
             (errors == errs0) ? "ok" : "failed");
  endtask

  initial begin
    int k;
    int low_cycles; // spi_resn low time after reset release
    seed   = 79;
    errors = 0;
    checks = 0;
    tests  = 0;
    limit  = (`LCD_RESET_CYCLES + 2 * `LCD_WAIT_CYCLES + 5 * 16 + 3 + 160) * 5 / 4;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // panel reset pulse before the init bytes
    low_cycles = 0;
    @(negedge clk);
    while (spi_resn !== 1'b1) begin
      low_cycles++;
      @(negedge clk);
    end
    checks++;
    assert (low_cycles == `LCD_RESET_CYCLES) else begin
      $display("Mismatch at %0t: spi_resn low for %0d cycles, expected %0d",
               $time, low_cycles, `LCD_RESET_CYCLES);
      errors++;
    end

    // init sequence comes first
    exp_q.delete();
    push_byte(0, `CMD_SWRESET);
    push_byte(0, `CMD_SLPOUT);
    push_byte(0, `CMD_COLMOD);
    push_byte(1, 8'h55);
    push_byte(0, `CMD_DISPON);
    while (got_q.size() < 5) @(negedge clk);
    repeat (64) @(negedge clk);
    compare_stream("init", 0);
    tests++;
    $display("test %0d init: %0d bytes, %s", tests, got_q.size(), (errors == 0) ? "ok" : "failed");

    set_points(2); // right to left, start is the smaller x
    px[0] = 330; py[0] = 40;
    px[1] = 300; py[1] = 40;
    run_polyline("horizontal", 16'hf800, 0);
    px[0] = 5; py[0] = 250;
    px[1] = 5; py[1] = 270;
    run_polyline("vertical", 16'h07e0, 0);
    px[0] = 10; py[0] = 10;
    px[1] = 30; py[1] = 30;
    run_polyline("diagonal", 16'h001f, 0);

    random_points();
    run_polyline("random", 16'($random(seed)), 0);

    set_points(5); // point 2 opens a new segment
    px[0] = 20;  py[0] = 20;
    px[1] = 60;  py[1] = 30;
    px[2] = 100; py[2] = 90;
    px[3] = 120; py[3] = 60;
    px[4] = 90;  py[4] = 10;
    ns[2] = 1;
    run_polyline("new_seg", 16'h1234, 0);

    set_points(4);
    px[0] = 200; py[0] = 5;
    px[1] = 260; py[1] = 25;
    px[2] = 240; py[2] = 70;
    px[3] = 210; py[3] = 40;
    run_polyline("plot while busy", 16'hbeef, 1);

    for (k = 0; k < 20; k++) begin
      random_points();
      run_polyline($sformatf("random %0d", k), 16'($random(seed)), 0);
    end

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== polyline_lcd_sva.sv ====
// handshake and spi checker
`timescale 1ns/1ps
`default_nettype none

module polyline_lcd_sva (
  input logic clk,
  input logic reset,
  input logic plot,    // request of a plot/busy pair
  input logic busy,    // its accept
  input logic rst_low, // must read 0 right after reset
  input logic csn,
  input logic resn,
  input logic dc
);

  a_csn_in_lcd_reset: assert property (@(posedge clk) disable iff (reset)
    !resn |-> csn)
    else $error("spi_csn low while spi_resn is low");

  // dc fixed for the whole byte
  a_dc_stable: assert property (@(posedge clk) disable iff (reset)
    (!csn && !$past(csn)) |-> $stable(dc))
    else $error("spi_dc changed within a byte");

  a_plot_rise: assert property (@(posedge clk) disable iff (reset)
    $rose(plot) |-> !busy)
    else $error("plot rose while busy was high");

  a_after_reset: assert property (@(posedge clk)
    ($past(reset) && !reset) |-> !rst_low)
    else $error("busy not low in the cycle after reset");

endmodule

// reader side, line handshake and host busy
bind polyline_reader polyline_lcd_sva u_reader_sva (
  .clk     (clk),
  .reset   (reset),
  .plot    (line.plot),
  .busy    (line.busy),
  .rst_low (busy),
  .csn     (1'b1),
  .resn    (1'b1),
  .dc      (1'b0)
);

// writer side, run handshake and spi pins
bind lcd_hvline polyline_lcd_sva u_lcd_sva (
  .clk     (clk),
  .reset   (reset),
  .plot    (run.plot),
  .busy    (run.busy),
  .rst_low (!spi_csn), // bus idle after reset
  .csn     (spi_csn),
  .resn    (spi_resn),
  .dc      (spi_dc)
);

`default_nettype wire

// ==== polyline_lcd.sv ====
// polyline display top level
`timescale 1ns/1ps
`default_nettype none
`include "polyline_lcd_cfg.svh"

module polyline_lcd (
  input  logic               clk,
  input  logic               reset,
  input  logic               plot,     // one cycle strobe, ignored while busy
  output logic               busy,
  input  logic [15:0]        data,     // coordinate memory read data
  input  logic [15:0]        color,    // rgb565
  output logic [`BUF_AW-1:0] addr,
  output logic               rd,
  output logic               spi_csn,
  output logic               spi_clk,
  output logic               spi_mosi,
  output logic               spi_dc,
  output logic               spi_resn
);

  line_if line_bus (); // reader -> drawer
  run_if  run_bus ();  // drawer -> writer

  polyline_reader u_reader (
    .clk   (clk),
    .reset (reset),
    .plot  (plot),
    .busy  (busy),
    .data  (data),
    .color (color),
    .addr  (addr),
    .rd    (rd),
    .line  (line_bus.producer)
  );

  draw_line u_draw (
    .clk   (clk),
    .reset (reset),
    .line  (line_bus.consumer),
    .run   (run_bus.producer)
  );

  lcd_hvline u_lcd (
    .clk      (clk),
    .reset    (reset),
    .run      (run_bus.consumer),
    .spi_csn  (spi_csn),
    .spi_clk  (spi_clk),
    .spi_mosi (spi_mosi),
    .spi_dc   (spi_dc),
    .spi_resn (spi_resn)
  );

endmodule

`default_nettype wire

// ==== lcd_hvline.sv ====
// st7789 spi run writer
`timescale 1ns/1ps
`default_nettype none
`include "polyline_lcd_cfg.svh"

module lcd_hvline import polyline_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  run_if.consumer  run,
  output logic     spi_csn,
  output logic     spi_clk,  // idle high, clk/2
  output logic     spi_mosi,
  output logic     spi_dc,   // 0 command, 1 data
  output logic     spi_resn
);

  typedef enum logic [2:0] {S_RST, S_INIT, S_WAIT, S_IDLE, S_HDR, S_PIX} state_t;

  state_t      st;
  logic [15:0] wcnt;       // reset and pause counter
  logic [2:0]  ii;         // init table index
  logic [8:0]  init_ent;   // {dc, byte}
  logic        init_wait;  // entry is followed by a pause
  logic [3:0]  bi;         // window header byte index
  logic [15:0] pix_left;
  logic        pix_lo;     // low byte of pixel next
  run_t        rq;
  logic [15:0] xs, xe, ys, ye;
  logic [7:0]  hdr_byte;
  logic        tx_idle, tx_ld, tx_dc;
  logic [7:0]  tx_byte;
  logic [7:0]  sh;         // remaining bits, msb first
  logic [3:0]  cnt;        // half spi_clk periods of the byte

  assign run.busy = (st != S_IDLE); // also covers reset and init
  assign tx_idle  = spi_csn;

  // window corners
  assign xs = {1'b0, rq.x};
  assign ys = {1'b0, rq.y};
  assign xe = rq.vertical ? xs : xs + rq.len - 16'd1;
  assign ye = rq.vertical ? ys + rq.len - 16'd1 : ys;

  // constant init table
  always_comb begin
    case (ii)
      3'd0:    init_ent = {1'b0, `CMD_SWRESET};
      3'd1:    init_ent = {1'b0, `CMD_SLPOUT};
      3'd2:    init_ent = {1'b0, `CMD_COLMOD};
      3'd3:    init_ent = {1'b1, 8'h55}; // 16 bit rgb565
      default: init_ent = {1'b0, `CMD_DISPON};
    endcase
  end
  assign init_wait = (ii < 3'd2);

  always_comb begin
    case (bi)
      4'd0:    hdr_byte = `CMD_CASET;
      4'd1:    hdr_byte = xs[15:8];
      4'd2:    hdr_byte = xs[7:0];
      4'd3:    hdr_byte = xe[15:8];
      4'd4:    hdr_byte = xe[7:0];
      4'd5:    hdr_byte = `CMD_RASET;
      4'd6:    hdr_byte = ys[15:8];
      4'd7:    hdr_byte = ys[7:0];
      4'd8:    hdr_byte = ye[15:8];
      4'd9:    hdr_byte = ye[7:0];
      default: hdr_byte = `CMD_RAMWR;
    endcase
  end

  // next byte for the shifter
  always_comb begin
    tx_ld   = 1'b0;
    tx_dc   = 1'b1;
    tx_byte = 8'h00;
    case (st)
      S_INIT: begin
        tx_ld            = tx_idle;
        {tx_dc, tx_byte} = init_ent;
      end
      S_HDR: begin
        tx_ld   = tx_idle;
        tx_dc   = !(bi == 4'd0 || bi == 4'd5 || bi == 4'd10); // command slots
        tx_byte = hdr_byte;
      end
      S_PIX: begin
        tx_ld   = tx_idle && (pix_left != 16'd0);
        tx_byte = pix_lo ? rq.color[7:0] : rq.color[15:8]; // high byte first
      end
      default: ;
    endcase
  end

  // byte shifter, csn low 16 cycles then one idle cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      spi_csn  <= 1'b1;
      spi_clk  <= 1'b1;
      spi_mosi <= 1'b0;
      spi_dc   <= 1'b0;
      cnt      <= '0;
    end else if (tx_ld) begin
      spi_csn  <= 1'b0;
      spi_clk  <= 1'b0;       // first falling edge with bit 7
      spi_mosi <= tx_byte[7];
      spi_dc   <= tx_dc;
      cnt      <= '0;
    end else if (!spi_csn) begin
      cnt <= cnt + 1'b1;
      if (!cnt[0]) begin
        spi_clk <= 1'b1;      // rising edge, display samples
      end else if (cnt == 4'd15) begin
        spi_csn <= 1'b1;      // clock already back high
      end else begin
        spi_clk  <= 1'b0;
        spi_mosi <= sh[7];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tx_ld)
      sh <= {tx_byte[6:0], 1'b0};
    else if (!spi_csn && cnt[0] && cnt != 4'd15)
      sh <= {sh[6:0], 1'b0};
  end

  // run payload and byte counters
  always_ff @(posedge clk) begin
    if (st == S_IDLE && run.plot) begin
      rq       <= run.rec;
      bi       <= '0;
      pix_left <= run.rec.len;
      pix_lo   <= 1'b0;
    end
    if (st == S_HDR && tx_ld)
      bi <= bi + 1'b1;
    if (st == S_PIX && tx_ld) begin
      pix_lo <= ~pix_lo;
      if (pix_lo)
        pix_left <= pix_left - 1'b1; // pixel complete
    end
  end

  // reset, init and transaction sequencer
  always_ff @(posedge clk) begin
    if (reset) begin
      st       <= S_RST;
      spi_resn <= 1'b0;
      wcnt     <= '0;
      ii       <= '0;
    end else begin
      case (st)
        S_RST: if (wcnt == 16'(`LCD_RESET_CYCLES - 1)) begin
          spi_resn <= 1'b1;
          wcnt     <= '0;
          st       <= S_INIT;
        end else begin
          wcnt <= wcnt + 1'b1;
        end
        S_INIT: if (tx_ld) begin
          ii <= ii + 1'b1;
          if (init_wait)
            st <= S_WAIT;
          else if (ii == 3'd4)
            st <= S_IDLE; // DISPON sent, ready for runs
        end
        S_WAIT: if (tx_idle) begin // pause counts from end of command
          if (wcnt == 16'(`LCD_WAIT_CYCLES - 1)) begin
            wcnt <= '0;
            st   <= S_INIT;
          end else begin
            wcnt <= wcnt + 1'b1;
          end
        end
        S_IDLE: if (run.plot) st <= S_HDR;
        S_HDR: if (tx_ld && bi == 4'd10) st <= S_PIX; // RAMWR loaded
        S_PIX: if (pix_left == 16'd0) st <= S_IDLE;
        default: st <= S_RST;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== draw_line.sv ====
// bresenham run generator
`timescale 1ns/1ps
`default_nettype none

module draw_line import polyline_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  line_if.consumer line,
  run_if.producer  run
);

  typedef enum logic [1:0] {S_IDLE, S_STEP, S_REQ, S_ACK} state_t;

  state_t             st;
  logic               busy;
  coord_t             cx, cy;        // current pixel
  coord_t             ex, ey;        // end point
  coord_t             dx, dy;        // absolute deltas
  coord_t             ldx, ldy;      // deltas of the offered line
  logic               sx_neg, sy_neg;
  logic               xmaj;          // x is the major axis
  logic               final_run;     // pending run ends the line
  logic signed [16:0] err;
  logic signed [17:0] err_nxt;
  logic signed [17:0] e2;
  logic signed [17:0] dx_s, dy_s;
  logic               step_x, step_y;
  logic               at_end, minor_step;
  logic               accept, emit, advance;
  coord_t             nx, ny;
  coord_t             cur_m, nxt_m;  // major coordinate now / next
  coord_t             run_m;         // major coordinate of first pixel in run
  coord_t             run_lo;        // smaller end of the run
  logic [15:0]        run_len;       // pixels already in the run
  logic [15:0]        len_nxt;
  color_t             color_q;
  run_t               rec;

  assign ldx = (line.x1 >= line.x0) ? line.x1 - line.x0 : line.x0 - line.x1;
  assign ldy = (line.y1 >= line.y0) ? line.y1 - line.y0 : line.y0 - line.y1;

  assign dx_s = signed'({3'b000, dx});
  assign dy_s = signed'({3'b000, dy});
  assign e2   = {err, 1'b0}; // twice the error

  assign step_x  = (e2 > -dy_s);
  assign step_y  = (e2 < dx_s);
  assign err_nxt = err - (step_x ? dy_s : 18'sd0) + (step_y ? dx_s : 18'sd0);

  assign nx = step_x ? (sx_neg ? cx - 1'b1 : cx + 1'b1) : cx;
  assign ny = step_y ? (sy_neg ? cy - 1'b1 : cy + 1'b1) : cy;

  assign at_end     = (cx == ex) && (cy == ey);
  assign minor_step = xmaj ? step_y : step_x; // minor coordinate changes
  assign cur_m      = xmaj ? cx : cy;
  assign nxt_m      = xmaj ? nx : ny;
  assign run_lo     = (cur_m < run_m) ? cur_m : run_m;
  assign len_nxt    = run_len + 1'b1;

  assign accept  = (st == S_IDLE) && line.plot;
  assign emit    = (st == S_STEP) && (at_end || minor_step);
  assign advance = (st == S_STEP) && !at_end;

  assign line.busy = busy;
  assign run.rec   = rec;

  // datapath, one pixel per STEP cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      cx      <= line.x0;
      cy      <= line.y0;
      ex      <= line.x1;
      ey      <= line.y1;
      dx      <= ldx;
      dy      <= ldy;
      sx_neg  <= (line.x1 < line.x0);
      sy_neg  <= (line.y1 < line.y0);
      xmaj    <= (ldx >= ldy);
      err     <= signed'({2'b00, ldx}) - signed'({2'b00, ldy});
      run_m   <= (ldx >= ldy) ? line.x0 : line.y0;
      run_len <= '0;
      color_q <= line.color;
    end
    if (emit) begin
      rec.x        <= xmaj ? run_lo : cx;
      rec.y        <= xmaj ? cy : run_lo;
      rec.len      <= len_nxt;
      rec.vertical <= ~xmaj;
      rec.color    <= color_q;
      final_run    <= at_end;
      run_len      <= '0;
      run_m        <= nxt_m; // next run begins at the next pixel
    end else if (advance) begin
      run_len <= len_nxt;
    end
    if (advance) begin
      cx  <= nx;
      cy  <= ny;
      err <= err_nxt[16:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      st       <= S_IDLE;
      busy     <= 1'b0;
      run.plot <= 1'b0;
    end else begin
      case (st)
        S_IDLE: if (line.plot) begin
          busy <= 1'b1;
          st   <= S_STEP;
        end
        S_STEP: if (emit) st <= S_REQ;
        S_REQ: if (!run.busy) begin // writer free
          run.plot <= 1'b1;
          st       <= S_ACK;
        end
        S_ACK: if (run.busy) begin  // run taken
          run.plot <= 1'b0;
          if (final_run) begin
            busy <= 1'b0;
            st   <= S_IDLE;
          end else begin
            st <= S_STEP;
          end
        end
        default: st <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== polyline_reader.sv ====
// polyline coordinate reader
`timescale 1ns/1ps
`default_nettype none
`include "polyline_lcd_cfg.svh"

module polyline_reader import polyline_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               plot,  // host strobe
  output logic               busy,
  input  coord_word_u        data,  // valid the cycle after rd
  input  color_t             color, // taken with an accepted plot
  output logic [`BUF_AW-1:0] addr,
  output logic               rd,
  line_if.producer           line
);

  typedef enum logic [2:0] {S_IDLE, S_ADDR, S_DATA, S_REQ, S_ACK, S_DONE} state_t;

  state_t             st;
  logic [`BUF_AW-1:0] ptr;       // word address
  logic [`BUF_AW-1:0] ptr_nxt;
  logic               full;      // a start point is held
  logic               last;      // last flag seen on the newest y word
  logic               cur_hi;    // newest point lives in slots 2/3
  coord_t             pt [0:3];  // x, y, x, y of two points
  color_t             color_q;

  assign ptr_nxt = ptr + 1'b1;
  assign addr    = ptr;
  assign rd      = (st == S_ADDR); // address cycle

  // line goes from the older point to the newest one
  assign line.x0    = cur_hi ? pt[0] : pt[2];
  assign line.y0    = cur_hi ? pt[1] : pt[3];
  assign line.x1    = cur_hi ? pt[2] : pt[0];
  assign line.y1    = cur_hi ? pt[3] : pt[1];
  assign line.color = color_q;

  // point buffer, slot picked by the low address bits
  always_ff @(posedge clk) begin
    if (st == S_DATA)
      pt[ptr[1:0]] <= data.xw.x; // x and y share bits 14:0
    if (st == S_IDLE && plot)
      color_q <= color;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      st        <= S_IDLE;
      busy      <= 1'b0;
      ptr       <= '0;
      full      <= 1'b0;
      last      <= 1'b0;
      cur_hi    <= 1'b0;
      line.plot <= 1'b0;
    end else begin
      case (st)
        S_IDLE: if (plot && !busy) begin
          busy <= 1'b1;
          ptr  <= '0;
          full <= 1'b0; // first point has nothing to connect to
          last <= 1'b0;
          st   <= S_ADDR;
        end
        S_ADDR: st <= S_DATA; // memory answers next edge
        S_DATA: begin
          ptr <= ptr_nxt;
          if (!ptr[0]) begin // x word
            if (data.xw.new_seg)
              full <= 1'b0;
            st <= S_ADDR;
          end else begin     // y word completes a point
            cur_hi <= ptr[1];
            full   <= 1'b1;
            last   <= data.yw.last;
            if (full)
              st <= S_REQ;
            else if (data.yw.last || ptr_nxt == '0)
              st <= S_DONE; // nothing to draw, stop here
            else
              st <= S_ADDR;
          end
        end
        S_REQ: if (!line.busy) begin
          line.plot <= 1'b1;
          st        <= S_ACK;
        end
        S_ACK: if (line.busy) begin // drawer took the line
          line.plot <= 1'b0;
          if (last || ptr == '0) // last point or address wrapped
            st <= S_DONE;
          else
            st <= S_ADDR;
        end
        S_DONE: if (!line.busy) begin // drawer has handed off its last run
          busy <= 1'b0;
          st   <= S_IDLE;
        end
        default: st <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== draw_if.sv ====
// drawing handshake interfaces
`timescale 1ns/1ps
`default_nettype none

// reader to line drawer
// producer waits for busy low, raises plot, holds it and the data until busy goes high
interface line_if import polyline_pkg::*; ();
  logic   plot;   // line request
  logic   busy;   // drawer working, also acts as accept
  coord_t x0, y0; // start point
  coord_t x1, y1; // end point
  color_t color;

  modport producer (output plot, x0, y0, x1, y1, color, input busy);
  modport consumer (input plot, x0, y0, x1, y1, color, output busy);
endinterface

// line drawer to display writer, same handshake
interface run_if import polyline_pkg::*; ();
  logic plot; // run request
  logic busy; // writer busy, high during lcd init too
  run_t rec;  // run payload

  modport producer (output plot, rec, input busy);
  modport consumer (input plot, rec, output busy);
endinterface

`default_nettype wire

// ==== polyline_pkg.sv ====
// polyline drawing types
`default_nettype none

package polyline_pkg;

  typedef logic [14:0] coord_t; // display coordinate
  typedef logic [15:0] color_t; // rgb565 pixel

  // word at an even address
  typedef struct packed {
    logic   new_seg; // start a new segment, no line into this point
    coord_t x;
  } x_word_t;

  // word at an odd address
  typedef struct packed {
    logic   last;    // final point of the polyline
    coord_t y;
  } y_word_t;

  // one memory word, meaning chosen by address parity
  typedef union packed {
    x_word_t xw;
    y_word_t yw;
  } coord_word_u;

  // horizontal or vertical run handed to the display writer
  typedef struct packed {
    coord_t      x;        // leftmost / topmost pixel
    coord_t      y;
    logic [15:0] len;      // pixel count, never zero
    logic        vertical; // run grows along y
    color_t      color;
  } run_t;

endpackage

`default_nettype wire

// ==== polyline_lcd_cfg.svh ====
// polyline lcd configuration
`ifndef POLYLINE_LCD_CFG_SVH
`define POLYLINE_LCD_CFG_SVH

// system clock in MHz, spi_clk runs at half of it
`define CLK_MHZ 250

// spi_resn low time after reset, kept short for simulation
`define LCD_RESET_CYCLES 64

// pause after SWRESET and after SLPOUT (real panels need ~120 ms)
`define LCD_WAIT_CYCLES 128

// coordinate memory, 1024 words of 16 bits
`define BUF_AW 10

// ST7789 command bytes
`define CMD_SWRESET 8'h01
`define CMD_SLPOUT  8'h11
`define CMD_DISPON  8'h29
`define CMD_CASET   8'h2A // column window
`define CMD_RASET   8'h2B // row window
`define CMD_RAMWR   8'h2C // pixel stream follows
`define CMD_COLMOD  8'h3A // pixel format, 0x55 selects rgb565

`endif
